// ==== src.f ====
+incdir+source
source/cpu_pkg.sv
source/microcode_sequencer.sv
source/datapath.sv
source/data_ram_arbiter.sv
source/data_ram.sv
source/cpu_core_top.sv
testbench/clock_gen.sv
testbench/cpu_core_tb.sv

// ==== testbench/cpu_core_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu_core_tb;

  typedef struct packed {
    logic [3:0] op;
    logic [7:0] operand;
    logic [7:0] addr;
  } instr_t;

  wire              clk;
  wire              reset_n;
  cpu_pkg::opcode_t opcode;
  logic [7:0]       operand;
  logic [7:0]       addr;
  logic [14:0]      irq_req;
  logic             host_rd_en;
  logic [7:0]       host_addr;
  wire              fetch;
  wire              halted;
  wire              host_rd_valid;
  wire  [3:0]       host_rd_data;

  // Reference model state
  logic [3:0] m_a;
  logic [3:0] m_b;
  logic       m_zero;
  logic       m_carry;
  logic       m_ie;
  logic [3:0] m_ram [256];
  bit         touched [256];

  instr_t     program_q [$];
  string      test_name;
  integer     seed = 32'habcd;
  int         cycle_no = 0;
  int         timeout_limit = 60;
  int         programs_done = 0;
  int         checks_done = 0;
  logic [7:0] stable_addrs [5] = '{8'h10, 8'h27, 8'h3c, 8'h9a, 8'hc5};
  logic [3:0] stable_vals [5] = '{4'h5, 4'ha, 4'hf, 4'h0, 4'h7};

  clock_gen u_clock_gen (.clk, .reset_n);

  cpu_core_top uut (
    .clk, .reset_n, .opcode, .operand, .addr, .irq_req, .fetch, .halted,
    .host_rd_en, .host_addr, .host_rd_valid, .host_rd_data
  );

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1, "stopped at first error");
  endtask

  // Instruction lengths in cycles from DECODE to DECODE
  function automatic int instr_cycles(input logic [3:0] op);
    case (op)
      cpu_pkg::OP_LDI, cpu_pkg::OP_MOVB, cpu_pkg::OP_EI: return 5;
      default: return 7;
    endcase
  endfunction

  // Interrupt fires as soon as ie is set and a line is up
  function automatic void take_model_irq();
    int winner;
    if (m_ie && irq_req != '0) begin
      // Scan down from the top line
      winner = cpu_pkg::IRQ_LINES - 1;
      while (!irq_req[winner]) begin
        winner--;
      end
      m_ram[cpu_pkg::IRQ_VECTOR_ADDR] = 4'(winner);
      touched[cpu_pkg::IRQ_VECTOR_ADDR] = 1'b1;
      m_ie = 1'b0;
    end
  endfunction

  function automatic void ref_exec(input instr_t ins);
    int sum;
    sum = 0;
    case (ins.op)
      cpu_pkg::OP_LDI: m_a = ins.operand[3:0];
      cpu_pkg::OP_LD: m_a = m_ram[ins.addr];
      cpu_pkg::OP_ST: begin
        m_ram[ins.addr] = m_a;
        touched[ins.addr] = 1'b1;
      end
      cpu_pkg::OP_MOVB: m_b = m_a;
      cpu_pkg::OP_ADD: begin
        sum = int'(m_a) + int'(m_b);
        m_a = 4'(sum % 16);
        m_carry = sum > 15;
        m_zero = m_a == 4'h0;
      end
      cpu_pkg::OP_SUB: begin
        // Borrow when B is the larger operand
        m_carry = m_b > m_a;
        m_a = 4'((int'(m_a) - int'(m_b) + 16) % 16);
        m_zero = m_a == 4'h0;
      end
      cpu_pkg::OP_AND: begin
        m_a = m_a & m_b;
        m_carry = 1'b0;
        m_zero = m_a == 4'h0;
      end
      cpu_pkg::OP_EI: m_ie = 1'b1;
      default: ;
    endcase
    take_model_irq();
  endfunction

  task automatic push_instr(input cpu_pkg::opcode_t op, input logic [7:0] imm,
                            input logic [7:0] mem_addr);
    instr_t ins;
    ins.op = op;
    ins.operand = imm;
    ins.addr = mem_addr;
    program_q.push_back(ins);
  endtask

  task automatic apply_instr(input instr_t ins);
    opcode = cpu_pkg::opcode_t'(ins.op);
    operand = ins.operand;
    addr = ins.addr;
    ref_exec(ins);
  endtask

  // Starts from a halted core and feeds one entry per fetch pulse
  task automatic run_program();
    int idx;
    int last_fetch;
    timeout_limit += 2 * 12 * program_q.size();
    apply_instr(program_q[0]);
    idx = 1;
    last_fetch = -1;
    while (idx < program_q.size()) begin
      @(posedge clk);
      #1;
      // Once the first pulse is seen the core has work until HALT
      assert (last_fetch < 0 || !halted)
        else fail_run("core raised halted while the program was still running");
      if (fetch) begin
        // Gap equals the length of the entry applied at the previous pulse
        if (irq_req == '0 && last_fetch >= 0) begin
          assert (cycle_no - last_fetch == instr_cycles(program_q[idx-1].op))
            else fail_run($sformatf("ERR %s fetch gap expected %0d actual %0d", test_name,
                                    instr_cycles(program_q[idx-1].op), cycle_no - last_fetch));
        end
        last_fetch = cycle_no;
        apply_instr(program_q[idx]);
        idx++;
      end
    end
    do begin
      @(posedge clk);
      #1;
    end while (!halted);
  endtask

  task automatic host_read(input logic [7:0] a, output logic [3:0] data);
    int waited;
    timeout_limit += 2 * 20;
    host_addr = a;
    host_rd_en = 1'b1;
    waited = 0;
    do begin
      @(posedge clk);
      #1;
      host_rd_en = 1'b0;
      waited++;
    end while (!host_rd_valid && waited < 20);
    assert (host_rd_valid)
      else fail_run($sformatf("host read of address %02h never returned data", a));
    data = host_rd_data;
  endtask

  task automatic check_value(input logic [7:0] a, input logic [3:0] exp,
                             input logic [3:0] got);
    assert (got === exp)
      else fail_run($sformatf("ERR %s addr %02h expected %h actual %h",
                              test_name, a, exp, got));
  endtask

  // Reads of addresses that the running program never writes
  task automatic background_reads();
    logic [3:0] got;
    logic [7:0] a;
    int k;
    for (k = 0; k < 16; k++) begin
      repeat (3 + k % 5) begin
        @(posedge clk);
        #1;
      end
      a = stable_addrs[k % 5];
      host_read(a, got);
      check_value(a, m_ram[a], got);
    end
  endtask

  task automatic run_test(input string name);
    test_name = name;
    push_instr(cpu_pkg::OP_HALT, 8'h00, 8'h00);
    run_program();
    programs_done++;
    wait (checks_done == programs_done);
    program_q.delete();
  endtask

  initial begin : watchdog
    while (cycle_no <= timeout_limit) begin
      @(posedge clk);
      cycle_no++;
    end
    fail_run($sformatf("timeout after %0d cycles, the core stopped responding", cycle_no));
  end

  initial begin : compare
    logic [3:0] got;
    forever begin
      wait (programs_done > checks_done);
      for (int a = 0; a < 256; a++) begin
        if (touched[a]) begin
          host_read(8'(a), got);
          check_value(8'(a), m_ram[a], got);
        end
      end
      checks_done++;
    end
  end

  initial begin : stimulus
    logic [31:0] rnd;
    int k;
    opcode = cpu_pkg::OP_HALT;
    operand = 8'h00;
    addr = 8'h00;
    irq_req = '0;
    host_rd_en = 1'b0;
    host_addr = 8'h00;
    m_a = 4'h0;
    m_b = 4'h0;
    m_zero = 1'b0;
    m_carry = 1'b0;
    m_ie = 1'b0;
    wait (reset_n === 1'b1);
    // Core parks on the HALT held since reset
    do begin
      @(posedge clk);
      #1;
    end while (!halted);

    for (k = 0; k < 5; k++) begin
      push_instr(cpu_pkg::OP_LDI, {4'h0, stable_vals[k]}, 8'h00);
      push_instr(cpu_pkg::OP_ST, 8'h00, stable_addrs[k]);
    end
    run_test("ldi_st");

    // ADD wraps with carry and SUB borrows
    push_instr(cpu_pkg::OP_LD, 8'h00, 8'h3c);
    push_instr(cpu_pkg::OP_MOVB, 8'h00, 8'h00);
    push_instr(cpu_pkg::OP_LDI, 8'h03, 8'h00);
    push_instr(cpu_pkg::OP_ADD, 8'h00, 8'h00);
    push_instr(cpu_pkg::OP_ST, 8'h00, 8'h61);
    push_instr(cpu_pkg::OP_LD, 8'h00, 8'h10);
    push_instr(cpu_pkg::OP_SUB, 8'h00, 8'h00);
    push_instr(cpu_pkg::OP_ST, 8'h00, 8'h62);
    push_instr(cpu_pkg::OP_LDI, 8'h0a, 8'h00);
    push_instr(cpu_pkg::OP_AND, 8'h00, 8'h00);
    push_instr(cpu_pkg::OP_ST, 8'h00, 8'h63);
    run_test("alu_ops");

    // Lines 2, 5 and 9 up so line 9 wins once EI runs
    irq_req = 15'h0224;
    take_model_irq();
    push_instr(cpu_pkg::OP_EI, 8'h00, 8'h00);
    push_instr(cpu_pkg::OP_LDI, 8'h04, 8'h00);
    push_instr(cpu_pkg::OP_ST, 8'h00, 8'h70);
    run_test("irq_priority");

    // With ie clear the requests on lines 1 and 14 are ignored
    irq_req = 15'h4002;
    take_model_irq();
    push_instr(cpu_pkg::OP_LDI, 8'h06, 8'h00);
    push_instr(cpu_pkg::OP_ST, 8'h00, 8'h71);
    run_test("irq_masked");
    irq_req = '0;

    for (k = 0; k < 16; k++) begin
      rnd = $random(seed);
      push_instr(cpu_pkg::OP_LDI, rnd[7:0], 8'h00);
      push_instr(cpu_pkg::OP_ST, 8'h00, 8'h40 + 8'(k));
    end
    push_instr(cpu_pkg::OP_EI, 8'h00, 8'h00);
    run_test("random_init");

    // Random program over the initialised window 0x40..0x4f
    test_name = "random_program";
    for (k = 0; k < 200; k++) begin
      rnd = $random(seed);
      push_instr(cpu_pkg::opcode_t'({1'b0, rnd[2:0]}), rnd[15:8], 8'h40 + {4'h0, rnd[19:16]});
    end
    push_instr(cpu_pkg::OP_HALT, 8'h00, 8'h00);
    fork
      run_program();
      background_reads();
    join
    programs_done++;
    wait (checks_done == programs_done);

    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/clock_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module clock_gen (
  output logic clk,
  output logic reset_n
);

  // 4 ns period
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Reset held for the first 10 rising edges
  initial begin
    reset_n = 1'b0;
    repeat (10) @(posedge clk);
    #1 reset_n = 1'b1;
  end

endmodule

`default_nettype wire

// ==== source/cpu_core_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu_core_top (
  input  wire                          clk,
  input  wire                          reset_n,
  input  wire cpu_pkg::opcode_t        opcode,
  input  wire [7:0]                    operand,
  input  wire [7:0]                    addr,
  input  wire [cpu_pkg::IRQ_LINES-1:0] irq_req,
  output logic                         fetch,
  output logic                         halted,
  input  wire                          host_rd_en,
  input  wire [7:0]                    host_addr,
  output logic                         host_rd_valid,
  output logic [3:0]                   host_rd_data
);

  cpu_pkg::reg_sel_t   src_sel;
  cpu_pkg::reg_sel_t   dst_sel;
  cpu_pkg::alu_op_t    alu_operation;
  cpu_pkg::bus_cycle_t bus_cycle;
  logic                zero;
  logic                carry;
  logic                ie;
  logic [3:0]          irq_num;
  logic                core_mem_en;
  logic                core_mem_we;
  logic [7:0]          core_mem_addr;
  logic [3:0]          core_mem_wdata;
  logic [3:0]          core_mem_rdata;
  logic                ram_en;
  logic                ram_we;
  logic [7:0]          ram_addr;
  logic [3:0]          ram_wdata;
  logic [3:0]          ram_rdata;

  microcode_sequencer u_sequencer (
    .clk, .reset_n, .opcode, .zero, .carry, .ie, .irq_req,
    .fetch, .halted, .irq_num, .src_sel, .dst_sel, .alu_operation, .bus_cycle
  );

  datapath u_datapath (
    .clk, .reset_n, .src_sel, .dst_sel, .alu_operation, .bus_cycle,
    .operand, .addr, .irq_num, .zero, .carry, .ie,
    .core_mem_en, .core_mem_we, .core_mem_addr, .core_mem_wdata, .core_mem_rdata
  );

  // Host debug port shares the data RAM with the core
  data_ram_arbiter u_arbiter (
    .clk, .reset_n,
    .core_mem_en, .core_mem_we, .core_mem_addr, .core_mem_wdata, .core_mem_rdata,
    .host_rd_en, .host_addr, .host_rd_valid, .host_rd_data,
    .ram_en, .ram_we, .ram_addr, .ram_wdata, .ram_rdata
  );

  data_ram u_ram (
    .clk,
    .en    (ram_en),
    .we    (ram_we),
    .addr  (ram_addr),
    .wdata (ram_wdata),
    .rdata (ram_rdata)
  );

endmodule

`default_nettype wire

// ==== source/data_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

module data_ram (
  input  wire        clk,
  input  wire        en,
  input  wire        we,
  input  wire  [7:0] addr,
  input  wire  [3:0] wdata,
  output logic [3:0] rdata
);

  logic [3:0] mem [256];

  // Read-first, old contents come out on a write
  always_ff @(posedge clk) begin
    if (en) begin
      rdata <= mem[addr];
      if (we) begin
        mem[addr] <= wdata;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/data_ram_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

module data_ram_arbiter (
  input  wire        clk,
  input  wire        reset_n,
  input  wire        core_mem_en,
  input  wire        core_mem_we,
  input  wire  [7:0] core_mem_addr,
  input  wire  [3:0] core_mem_wdata,
  output logic [3:0] core_mem_rdata,
  input  wire        host_rd_en,
  input  wire  [7:0] host_addr,
  output logic       host_rd_valid,
  output logic [3:0] host_rd_data,
  output logic       ram_en,
  output logic       ram_we,
  output logic [7:0] ram_addr,
  output logic [3:0] ram_wdata,
  input  wire  [3:0] ram_rdata
);

  logic       host_pending;
  logic [7:0] pending_addr;
  logic       host_serve;
  logic [7:0] host_req_addr;
  logic       owner_host;

  // Core always wins, host takes the first free cycle
  assign host_req_addr = host_pending ? pending_addr : host_addr;
  assign host_serve = (host_rd_en || host_pending) && !core_mem_en;

  assign ram_en = core_mem_en || host_serve;
  assign ram_we = core_mem_en && core_mem_we;
  assign ram_addr = core_mem_en ? core_mem_addr : host_req_addr;
  assign ram_wdata = core_mem_wdata;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      host_pending <= 1'b0;
      owner_host <= 1'b0;
    end else begin
      owner_host <= host_serve;
      if (host_serve) begin
        host_pending <= 1'b0;
      end else if (host_rd_en) begin
        host_pending <= 1'b1;
      end
    end
  end

  // Only one read waits, a strobe while busy keeps the first address
  always_ff @(posedge clk) begin
    if (host_rd_en && !host_pending) begin
      pending_addr <= host_addr;
    end
  end

  assign host_rd_valid = owner_host;
  assign host_rd_data = owner_host ? ram_rdata : 4'h0;
  assign core_mem_rdata = owner_host ? 4'h0 : ram_rdata;

  a_host_served: assert property (@(posedge clk) disable iff (!reset_n)
    host_pending |-> ##[0:12] host_serve)
    else $error("host read starved by the core");

endmodule

`default_nettype wire

// ==== source/datapath.sv ====
`timescale 1ns/1ns
`default_nettype none

module datapath (
  input  wire                      clk,
  input  wire                      reset_n,
  input  wire cpu_pkg::reg_sel_t   src_sel,
  input  wire cpu_pkg::reg_sel_t   dst_sel,
  input  wire cpu_pkg::alu_op_t    alu_operation,
  input  wire cpu_pkg::bus_cycle_t bus_cycle,
  input  wire [7:0]                operand,
  input  wire [7:0]                addr,
  input  wire [3:0]                irq_num,
  output logic                     zero,
  output logic                     carry,
  output logic                     ie,
  output logic                     core_mem_en,
  output logic                     core_mem_we,
  output logic [7:0]               core_mem_addr,
  output logic [3:0]               core_mem_wdata,
  input  wire [3:0]                core_mem_rdata
);

  logic [3:0] reg_a;
  logic [3:0] reg_b;
  logic [3:0] bus_q;
  logic       alu_carry_q;
  logic [7:0] mem_addr_q;
  logic [4:0] alu_result;
  logic [3:0] bus_value;
  logic       fetch_phase;
  logic       write_phase;

  assign fetch_phase = bus_cycle == cpu_pkg::CYCLE_REG_FETCH;
  assign write_phase = bus_cycle == cpu_pkg::CYCLE_REG_WRITE;

  // Bit 4 is the carry out or the borrow, AND clears it
  always_comb begin
    case (alu_operation)
      cpu_pkg::ALU_ADD: alu_result = {1'b0, reg_a} + {1'b0, reg_b};
      cpu_pkg::ALU_SUB: alu_result = {1'b0, reg_a} - {1'b0, reg_b};
      cpu_pkg::ALU_AND: alu_result = {1'b0, reg_a & reg_b};
      default: alu_result = 5'd0;
    endcase
  end

  // Fetch phase: capture source and the address for a later RAM write
  always_ff @(posedge clk) begin
    if (fetch_phase) begin
      mem_addr_q <= (src_sel == cpu_pkg::SEL_IRQ_NUM) ? cpu_pkg::IRQ_VECTOR_ADDR : addr;
      alu_carry_q <= alu_result[4];
      case (src_sel)
        cpu_pkg::SEL_A: bus_q <= reg_a;
        cpu_pkg::SEL_B: bus_q <= reg_b;
        cpu_pkg::SEL_IMM: bus_q <= operand[3:0];
        cpu_pkg::SEL_ALU: bus_q <= alu_result[3:0];
        cpu_pkg::SEL_IRQ_NUM: bus_q <= irq_num;
        // Enable constant for EI
        cpu_pkg::SEL_IE: bus_q <= 4'h1;
        default: bus_q <= 4'h0;
      endcase
    end
  end

  // RAM data only shows up in the write phase
  assign bus_value = (src_sel == cpu_pkg::SEL_MEM) ? core_mem_rdata : bus_q;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      reg_a <= 4'h0;
      reg_b <= 4'h0;
      zero <= 1'b0;
      carry <= 1'b0;
      ie <= 1'b0;
    end else if (write_phase) begin
      case (dst_sel)
        cpu_pkg::SEL_A: reg_a <= bus_value;
        cpu_pkg::SEL_B: reg_b <= bus_value;
        cpu_pkg::SEL_IE: ie <= bus_value[0];
        default: ;
      endcase
      if (src_sel == cpu_pkg::SEL_ALU) begin
        zero <= bus_value == 4'h0;
        carry <= alu_carry_q;
      end
    end
  end

  assign core_mem_en = (fetch_phase && src_sel == cpu_pkg::SEL_MEM) ||
                       (write_phase && dst_sel == cpu_pkg::SEL_MEM);
  assign core_mem_we = write_phase && dst_sel == cpu_pkg::SEL_MEM;
  assign core_mem_addr = write_phase ? mem_addr_q : addr;
  assign core_mem_wdata = bus_value;

  // A read must be followed by the write phase that consumes its data
  a_read_in_fetch: assert property (@(posedge clk) disable iff (!reset_n)
    core_mem_en && !core_mem_we |->
      bus_cycle == cpu_pkg::CYCLE_REG_FETCH ##1 bus_cycle == cpu_pkg::CYCLE_REG_WRITE)
    else $error("RAM read outside a fetch/write pair");

endmodule

`default_nettype wire

// ==== source/microcode_sequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

module microcode_sequencer (
  input  wire                          clk,
  input  wire                          reset_n,
  input  wire cpu_pkg::opcode_t        opcode,
  input  wire                          zero,
  input  wire                          carry,
  input  wire                          ie,
  input  wire [cpu_pkg::IRQ_LINES-1:0] irq_req,
  output logic                         fetch,
  output logic                         halted,
  output logic [3:0]                   irq_num,
  output cpu_pkg::reg_sel_t            src_sel,
  output cpu_pkg::reg_sel_t            dst_sel,
  output cpu_pkg::alu_op_t             alu_operation,
  output cpu_pkg::bus_cycle_t          bus_cycle
);

  `include "microcode_table.svh"

  cpu_pkg::stage_t                  stage;
  cpu_pkg::instr_length_t           len_q;
  logic [cpu_pkg::UPC_W-1:0]        upc;
  logic                             ucode_active;
  logic                             in_irq;
  logic                             irq_pending;
  logic [cpu_pkg::UCODE_WORD_W-1:0] uword;
  cpu_pkg::micro_op_t               uop;
  logic                             fetch_stage;
  logic                             write_stage;
  logic                             issue;
  logic                             jump_taken;
  logic                             last_stage;
  logic                             irq_request;
  logic                             take_irq;
  logic [3:0]                       irq_winner;

  assign uword = ucode_rom(upc);
  assign uop = cpu_pkg::micro_op_t'(uword[15:13]);

  always_comb begin
    fetch_stage = 1'b0;
    write_stage = 1'b0;
    case (stage)
      cpu_pkg::STEP1, cpu_pkg::STEP2, cpu_pkg::STEP3, cpu_pkg::STEP5, cpu_pkg::STEP6:
        fetch_stage = 1'b1;
      cpu_pkg::STEP1_2, cpu_pkg::STEP2_2, cpu_pkg::STEP3_2, cpu_pkg::STEP5_2,
      cpu_pkg::STEP6_2:
        write_stage = 1'b1;
      // DECODE and STEP4 carry no micro-op
      default: ;
    endcase
  end

  assign last_stage = int'(stage) + 1 == cpu_pkg::cycle_count(len_q);
  // The interrupt routine leaves the held instruction in place
  assign fetch = !in_irq && (int'(stage) + 2 == cpu_pkg::cycle_count(len_q));

  assign issue = ucode_active && (fetch_stage || write_stage) &&
                 (uop == cpu_pkg::UOP_TRANSFER || uop == cpu_pkg::UOP_TRANSALU);
  assign jump_taken = (uword[11] ? carry : zero) == uword[10];

  // Selectors hold across the fetch/write pair of one micro-op
  always_comb begin
    src_sel = cpu_pkg::SEL_NONE;
    dst_sel = cpu_pkg::SEL_NONE;
    alu_operation = cpu_pkg::ALU_ADD;
    bus_cycle = cpu_pkg::CYCLE_NONE;
    if (issue) begin
      bus_cycle = fetch_stage ? cpu_pkg::CYCLE_REG_FETCH : cpu_pkg::CYCLE_REG_WRITE;
      dst_sel = cpu_pkg::reg_sel_t'(uword[9:7]);
      if (uop == cpu_pkg::UOP_TRANSALU) begin
        src_sel = cpu_pkg::SEL_ALU;
        alu_operation = cpu_pkg::alu_op_t'(uword[12:11]);
      end else begin
        src_sel = cpu_pkg::reg_sel_t'(uword[12:10]);
      end
    end
  end

  assign irq_request = ie && |irq_req;
  assign take_irq = irq_pending || (irq_request && !in_irq);

  // Highest active line wins
  always_comb begin
    irq_winner = 4'd0;
    for (int i = 0; i < cpu_pkg::IRQ_LINES; i++) begin
      if (irq_req[i]) begin
        irq_winner = 4'(i);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      stage <= cpu_pkg::STEP6_2;
      len_q <= cpu_pkg::CYCLE12;
      upc <= '0;
      ucode_active <= 1'b0;
      in_irq <= 1'b0;
      irq_pending <= 1'b0;
      halted <= 1'b0;
    end else begin
      if (stage == cpu_pkg::DECODE && take_irq) begin
        irq_pending <= 1'b0;
      end else if (irq_request && !in_irq) begin
        irq_pending <= 1'b1;
      end

      if (stage == cpu_pkg::DECODE) begin
        in_irq <= take_irq;
        if (take_irq) begin
          stage <= cpu_pkg::STEP1;
          len_q <= cpu_pkg::CYCLE12;
          upc <= cpu_pkg::INTERRUPT_UADDR;
          ucode_active <= 1'b1;
          halted <= 1'b0;
        end else if (opcode == cpu_pkg::OP_HALT) begin
          // Poll the opcode every other cycle until the host moves on
          stage <= cpu_pkg::STEP6_2;
          len_q <= cpu_pkg::CYCLE12;
          ucode_active <= 1'b0;
          halted <= 1'b1;
        end else begin
          stage <= cpu_pkg::STEP1;
          len_q <= cpu_pkg::opcode_length(opcode);
          upc <= ucode_entry(opcode);
          ucode_active <= 1'b1;
          halted <= 1'b0;
        end
      end else begin
        if (last_stage) begin
          stage <= cpu_pkg::DECODE;
        end else begin
          stage <= cpu_pkg::stage_t'(stage + 4'd1);
        end
        // Micro-pc moves at the end of each write stage
        if (ucode_active && write_stage) begin
          if (uop == cpu_pkg::UOP_END) begin
            ucode_active <= 1'b0;
          end else if (uop == cpu_pkg::UOP_JMP && jump_taken) begin
            upc <= uword[cpu_pkg::UPC_W-1:0];
          end else begin
            upc <= upc + 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (stage == cpu_pkg::DECODE && take_irq) begin
      irq_num <= irq_winner;
    end
  end

  a_stage_in_length: assert property (@(posedge clk) disable iff (!reset_n)
    int'(stage) < cpu_pkg::cycle_count(len_q))
    else $error("stage %0d beyond instruction length", stage);

  a_fetch_pulse: assert property (@(posedge clk) disable iff (!reset_n)
    fetch |=> !fetch)
    else $error("fetch held longer than one cycle");

endmodule

`default_nettype wire

// ==== source/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

  // External instruction set, OP_HALT parks the core
  typedef enum logic [3:0] {
    OP_LDI,
    OP_LD,
    OP_ST,
    OP_MOVB,
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_EI,
    OP_HALT
  } opcode_t;

  typedef enum logic [1:0] {CYCLE5, CYCLE7, CYCLE12} instr_length_t;

  // DECODE and STEP4 are single cycles, the rest come as fetch/write pairs
  typedef enum logic [3:0] {
    DECODE,
    STEP1,
    STEP1_2,
    STEP2,
    STEP2_2,
    STEP3,
    STEP3_2,
    STEP4,
    STEP5,
    STEP5_2,
    STEP6,
    STEP6_2
  } stage_t;

  typedef enum logic [1:0] {CYCLE_NONE, CYCLE_REG_FETCH, CYCLE_REG_WRITE} bus_cycle_t;

  typedef enum logic [2:0] {
    SEL_NONE,
    SEL_A,
    SEL_B,
    SEL_IMM,
    SEL_MEM,
    SEL_ALU,
    SEL_IRQ_NUM,
    SEL_IE
  } reg_sel_t;

  typedef enum logic [1:0] {ALU_ADD, ALU_SUB, ALU_AND} alu_op_t;

  typedef enum logic [2:0] {UOP_NOP, UOP_TRANSFER, UOP_TRANSALU, UOP_JMP, UOP_END} micro_op_t;

  localparam int UCODE_WORD_W = 16;
  localparam int UPC_W = 8;
  localparam int IRQ_LINES = 15;
  localparam logic [7:0] IRQ_VECTOR_ADDR = 8'hff;
  localparam logic [UPC_W-1:0] INTERRUPT_UADDR = 8'd32;

  function automatic int cycle_count(input instr_length_t len);
    case (len)
      CYCLE5: return 5;
      CYCLE7: return 7;
      default: return 12;
    endcase
  endfunction

  // HALT never runs a micro-routine, so its length is not used
  function automatic instr_length_t opcode_length(input opcode_t op);
    case (op)
      OP_LDI, OP_MOVB, OP_EI: return CYCLE5;
      default: return CYCLE7;
    endcase
  endfunction

endpackage

`default_nettype wire

// ==== source/microcode_table.svh ====
`ifndef MICROCODE_TABLE_SVH
`define MICROCODE_TABLE_SVH

// Word layout
//   [15:13] micro-op
//   TRANSFER  [12:10] source, [9:7] destination
//   TRANSALU  [12:11] ALU operation, [9:7] destination
//   JMP       [11] flag (0 zero, 1 carry), [10] wanted value, [7:0] target
function automatic logic [cpu_pkg::UCODE_WORD_W-1:0] ucode_rom(
  input logic [cpu_pkg::UPC_W-1:0] uaddr
);
  logic [cpu_pkg::UCODE_WORD_W-1:0] word;
  word = {cpu_pkg::UOP_END, 13'd0};
  case (uaddr)
    8'd0:  word = {cpu_pkg::UOP_TRANSFER, cpu_pkg::SEL_IMM, cpu_pkg::SEL_A, 7'd0};
    8'd4:  word = {cpu_pkg::UOP_TRANSFER, cpu_pkg::SEL_MEM, cpu_pkg::SEL_A, 7'd0};
    8'd8:  word = {cpu_pkg::UOP_TRANSFER, cpu_pkg::SEL_A, cpu_pkg::SEL_MEM, 7'd0};
    8'd12: word = {cpu_pkg::UOP_TRANSFER, cpu_pkg::SEL_A, cpu_pkg::SEL_B, 7'd0};
    8'd16: word = {cpu_pkg::UOP_TRANSALU, cpu_pkg::ALU_ADD, 1'b0, cpu_pkg::SEL_A, 7'd0};
    8'd20: word = {cpu_pkg::UOP_TRANSALU, cpu_pkg::ALU_SUB, 1'b0, cpu_pkg::SEL_A, 7'd0};
    8'd24: word = {cpu_pkg::UOP_TRANSALU, cpu_pkg::ALU_AND, 1'b0, cpu_pkg::SEL_A, 7'd0};
    // EI, the IE source is the enable constant
    8'd28: word = {cpu_pkg::UOP_TRANSFER, cpu_pkg::SEL_IE, cpu_pkg::SEL_IE, 7'd0};
    // Interrupt routine: drop ie first so no second request queues up
    cpu_pkg::INTERRUPT_UADDR:
      word = {cpu_pkg::UOP_TRANSFER, cpu_pkg::SEL_NONE, cpu_pkg::SEL_IE, 7'd0};
    cpu_pkg::INTERRUPT_UADDR + 8'd1:
      word = {cpu_pkg::UOP_TRANSFER, cpu_pkg::SEL_IRQ_NUM, cpu_pkg::SEL_MEM, 7'd0};
    // Skip the padding slot when carry is clear
    cpu_pkg::INTERRUPT_UADDR + 8'd2:
      word = {cpu_pkg::UOP_JMP, 3'b010, 2'b00, cpu_pkg::INTERRUPT_UADDR + 8'd4};
    cpu_pkg::INTERRUPT_UADDR + 8'd3:
      word = {cpu_pkg::UOP_NOP, 13'd0};
    default: word = {cpu_pkg::UOP_END, 13'd0};
  endcase
  return word;
endfunction

// Entry points are four words apart
function automatic logic [cpu_pkg::UPC_W-1:0] ucode_entry(input cpu_pkg::opcode_t op);
  return {2'b00, op, 2'b00};
endfunction

`endif
